//--- trace_pkg.sv
// Instruction word views, class encoding and commit record types for the commit monitor.
// Shared by the classifiers, the counter bank and the register FSM.
package trace_pkg;

    localparam int NUM_CLASSES = 8;

    // RV32 base layout, low two bits are 11.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv32_fields_t;

    // compressed layout, only the low half is meaningful.
    typedef struct packed {
        logic [15:0] upper;
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  f11_7;
        logic [4:0]  f6_2;
        logic [1:0]  op;
    } rvc_fields_t;

    typedef union packed {
        rv32_fields_t rv;
        rvc_fields_t  c;
    } instr_word_u;

    typedef enum logic [3:0] {
        BASE   = 4'd0,
        MEXT   = 4'd1,
        LOAD   = 4'd2,
        STORE  = 4'd3,
        BRANCH = 4'd4,
        JAL    = 4'd5,
        JALR   = 4'd6,
        CSR    = 4'd7
    } itype_e;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       rs1_used;
        logic       rs2_used;
    } source_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       rd_used;
    } dest_t;

    typedef struct packed {
        source_t source;
        dest_t   dest;
        logic    rvc;
        itype_e  itype;
    } trace_record_t;

    // class_count is indexed by the itype value.
    typedef struct packed {
        logic [31:0]                        cycles;
        logic [31:0]                        retired;
        logic [31:0]                        rvc_count;
        logic [NUM_CLASSES-1:0][31:0]       class_count;
        trace_record_t                      last;
    } counter_bank_t;

endpackage

//--- axil_pkg.sv
// AXI4-Lite channel bundles and the register map of the commit monitor.
// Used by the register FSM and the top level.
package axil_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
    } axil_rsp_t;

    localparam logic [ADDR_W-1:0] REG_CTRL       = 8'h00;
    localparam logic [ADDR_W-1:0] REG_CYCLES     = 8'h04;
    localparam logic [ADDR_W-1:0] REG_RETIRED    = 8'h08;
    localparam logic [ADDR_W-1:0] REG_RVC        = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_LAST       = 8'h10;
    localparam logic [ADDR_W-1:0] REG_CLASS_BASE = 8'h14;
    localparam logic [ADDR_W-1:0] REG_CLASS_END  = 8'h30;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- rvc_classifier.sv
// Classifies a 16-bit compressed instruction into its class and register use.
// Purely combinational, the result always has the rvc flag set.
module rvc_classifier import trace_pkg::*; (
    input  instr_word_u   instr_i,
    output trace_record_t record_o
);

    rvc_fields_t   f;
    logic [4:0]    rs1p;
    logic [4:0]    rs2p;
    logic          rs1zero;
    logic          shamtzr;
    logic          alu_known;
    logic          known;
    trace_record_t rec;

    assign f       = instr_i.c;
    // 3-bit register fields address x8 to x15.
    assign rs1p    = {2'b01, f.f11_7[2:0]};
    assign rs2p    = {2'b01, f.f6_2[2:0]};
    assign rs1zero = f.f11_7 == 5'd0;
    assign shamtzr = f.f6_2 == 5'd0;

    assign alu_known = (f.f11_7[4:3] == 2'b10) || (!f.f11_7[4] && !shamtzr) ||
                       (f.f11_7[4:3] == 2'b11 && !f.b12);

    always_comb begin
        rec       = '0;
        rec.rvc   = 1'b1;
        rec.itype = BASE;
        known     = 1'b1;
        case ({f.op, f.funct3})
            5'b00_000: begin
                rec.source = {5'd2, 5'd0, 2'b10};
                rec.dest   = {rs2p, 1'b1};
                known      = {f.b12, f.f11_7, f.f6_2[4:3]} != 8'd0;
            end
            5'b00_010: begin
                rec.source = {rs1p, 5'd0, 2'b10};
                rec.dest   = {rs2p, 1'b1};
                rec.itype  = LOAD;
            end
            5'b00_110: begin
                rec.source = {rs1p, rs2p, 2'b11};
                rec.dest   = {rs2p, 1'b0};
                rec.itype  = STORE;
            end
            5'b01_000: begin
                rec.source = {f.f11_7, 5'd0, 2'b10};
                rec.dest   = {f.f11_7, 1'b1};
            end
            5'b01_001: begin
                rec.dest  = {5'd1, 1'b1};
                rec.itype = JAL;
            end
            5'b01_010: begin
                rec.source = {10'd0, 2'b10};
                rec.dest   = {f.f11_7, 1'b1};
            end
            5'b01_011: begin
                known = {f.b12, f.f6_2} != 6'd0;
                if (f.f11_7 == 5'd2) begin
                    rec.source = {5'd2, 5'd0, 2'b10};
                end
                rec.dest = {f.f11_7, 1'b1};
            end
            5'b01_100: begin
                known      = alu_known;
                rec.source = (f.f11_7[4:3] != 2'b11) ? {rs1p, 5'd0, 2'b10} : {rs1p, rs2p, 2'b11};
                rec.dest   = {rs1p, 1'b1};
            end
            5'b01_101: begin
                rec.dest  = {5'd0, 1'b1};
                rec.itype = JAL;
            end
            5'b01_110, 5'b01_111: begin
                rec.source = {rs1p, 5'd0, 2'b11};
                rec.dest   = {rs1p, 1'b0};
                rec.itype  = BRANCH;
            end
            5'b10_000: begin
                known      = !f.b12 && !rs1zero && !shamtzr;
                rec.source = {f.f11_7, 5'd0, 2'b10};
                rec.dest   = {f.f11_7, 1'b1};
            end
            5'b10_010: begin
                known      = !rs1zero;
                rec.source = {5'd2, 5'd0, 2'b10};
                rec.dest   = {f.f11_7, 1'b1};
                rec.itype  = LOAD;
            end
            5'b10_100: begin
                known = f.b12 || !rs1zero || !shamtzr;
                if (f.b12 && rs1zero && shamtzr) begin
                    rec.itype = CSR;
                end else if (!shamtzr) begin
                    // add reads both registers, mv only the 6:2 one.
                    rec.source = {f.b12 ? f.f11_7 : 5'd0, f.f6_2, 2'b11};
                    rec.dest   = {f.f11_7, 1'b1};
                end else begin
                    // jalr links through x1, jr drops the link into x0.
                    rec.source = {f.f11_7, 5'd0, 2'b10};
                    rec.dest   = {f.b12 ? 5'd1 : 5'd0, 1'b1};
                    rec.itype  = JALR;
                end
            end
            5'b10_110: begin
                rec.source = {5'd2, f.f6_2, 2'b11};
                rec.dest   = {f.f6_2, 1'b0};
                rec.itype  = STORE;
            end
            default: known = 1'b0;
        endcase
        // reserved encodings count as base with no register.
        if (!known) begin
            rec.source = '0;
            rec.dest   = '0;
            rec.itype  = BASE;
        end
    end

    assign record_o = rec;

endmodule

//--- instr_classifier.sv
// Classifies a retired instruction word into its class and register use.
// 32-bit words are decoded here, compressed words by the rvc classifier.
module instr_classifier import trace_pkg::*; (
    input  instr_word_u   instr_i,
    output trace_record_t record_o
);

    rv32_fields_t  f;
    logic [11:0]   imm12;
    logic          known;
    trace_record_t rec_32;
    trace_record_t rec_c;

    assign f     = instr_i.rv;
    assign imm12 = {f.funct7, f.rs2};

    rvc_classifier u_rvc_classifier (
        .instr_i  (instr_i),
        .record_o (rec_c)
    );

    always_comb begin
        rec_32       = '0;
        rec_32.itype = BASE;
        known        = 1'b1;
        case (f.opcode[6:2])
            5'b01101, 5'b00101: rec_32.dest = {f.rd, 1'b1};
            5'b11011: begin
                rec_32.dest  = {f.rd, 1'b1};
                rec_32.itype = JAL;
            end
            5'b11001: begin
                rec_32.source = {f.rs1, 5'd0, 2'b10};
                rec_32.dest   = {f.rd, 1'b1};
                rec_32.itype  = JALR;
                known         = f.funct3 == 3'd0;
            end
            5'b11000: begin
                rec_32.source = {f.rs1, f.rs2, 2'b11};
                rec_32.dest   = {f.rd, 1'b0};
                rec_32.itype  = BRANCH;
                known         = f.funct3[2:1] != 2'b01;
            end
            5'b00000: begin
                rec_32.source = {f.rs1, 5'd0, 2'b10};
                rec_32.dest   = {f.rd, 1'b1};
                rec_32.itype  = LOAD;
                known         = f.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            5'b01000: begin
                rec_32.source = {f.rs1, f.rs2, 2'b11};
                rec_32.dest   = {f.rd, 1'b0};
                rec_32.itype  = STORE;
                known         = f.funct3 < 3'd3;
            end
            5'b00100: begin
                // shift immediates carry funct7 in the upper bits.
                rec_32.source = {f.rs1, f.rs2, 2'b10};
                rec_32.dest   = {f.rd, 1'b1};
                known         = (f.funct3[1:0] != 2'b01) || (f.funct7 == 7'h00) ||
                                (f.funct3 == 3'd5 && f.funct7 == 7'h20);
            end
            5'b01100: begin
                rec_32.source = {f.rs1, f.rs2, 2'b11};
                rec_32.dest   = {f.rd, 1'b1};
                rec_32.itype  = f.funct7[0] ? MEXT : BASE;
                known         = (f.funct7 == 7'h00) || (f.funct7 == 7'h01) ||
                                (f.funct7 == 7'h20 && (f.funct3 == 3'd0 || f.funct3 == 3'd5));
            end
            5'b00011: begin
                rec_32.dest  = {f.rd, 1'b0};
                rec_32.itype = CSR;
                known        = f.funct3[2:1] == 2'b00;
            end
            5'b11100: begin
                rec_32.itype = CSR;
                if (f.rd == 5'd0 && f.rs1 == 5'd0) begin
                    known = f.funct3 == 3'd0 && (imm12 inside {12'h302, 12'h000, 12'h001});
                end else begin
                    // immediate forms do not read rs1.
                    if (!f.funct3[2]) begin
                        rec_32.source = {f.rs1, 5'd0, 2'b10};
                    end
                    rec_32.dest = {f.rd, 1'b1};
                    known       = f.funct3[1:0] != 2'b00;
                end
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            rec_32.source = '0;
            rec_32.dest   = '0;
            rec_32.itype  = BASE;
        end
    end

    assign record_o = (f.opcode[1:0] != 2'b11) ? rec_c : rec_32;

endmodule

//--- commit_counters.sv
// Retirement statistics of the commit monitor.
// Counts cycles, commits, compressed commits and commits per class, keeps the last record.
module commit_counters import trace_pkg::*; (
    input  logic          s_clk_i,
    input  logic          rst_n_i,
    input  logic          clear_i,
    input  logic          commit_valid_i,
    input  trace_record_t record_i,
    output counter_bank_t bank_o
);

    counter_bank_t bank_q;
    logic [2:0]    class_idx;

    assign class_idx = 3'(record_i.itype);

    // all counters wrap at 32 bits.
    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || clear_i) begin
            bank_q <= '0;
        end else begin
            bank_q.cycles <= bank_q.cycles + 32'd1;
            if (commit_valid_i) begin
                bank_q.retired                <= bank_q.retired + 32'd1;
                bank_q.class_count[class_idx] <= bank_q.class_count[class_idx] + 32'd1;
                if (record_i.rvc) begin
                    bank_q.rvc_count <= bank_q.rvc_count + 32'd1;
                end
                bank_q.last <= record_i;
            end
        end
    end

    assign bank_o = bank_q;

endmodule

//--- axil_regs_fsm.sv
// AXI4-Lite slave for the commit monitor registers.
// One transaction at a time, reads win over writes, a control write clears the counters.
module axil_regs_fsm import trace_pkg::*, axil_pkg::*; (
    input  logic          s_clk_i,
    input  logic          rst_n_i,
    input  axil_req_t     axil_req_i,
    output axil_rsp_t     axil_rsp_o,
    input  counter_bank_t bank_i,
    output logic          clear_o
);

    typedef enum logic [1:0] {IDLE, READ_RESP, WRITE_RESP} state_e;

    state_e            state_q;
    logic              ar_hs;
    logic              wr_hs;
    logic              wr_ctrl;
    logic              rd_err;
    logic [DATA_W-1:0] rd_data;
    logic [ADDR_W-1:0] class_off;
    logic [DATA_W-1:0] rdata_q;
    logic [1:0]        rresp_q;
    logic [1:0]        bresp_q;
    logic              clear_q;

    assign ar_hs     = (state_q == IDLE) && axil_req_i.arvalid;
    assign wr_hs     = (state_q == IDLE) && !axil_req_i.arvalid &&
                       axil_req_i.awvalid && axil_req_i.wvalid;
    assign wr_ctrl   = axil_req_i.awaddr == REG_CTRL;
    assign class_off = axil_req_i.araddr - REG_CLASS_BASE;

    // failed reads return zero.
    always_comb begin
        rd_data = '0;
        rd_err  = (axil_req_i.araddr[1:0] != 2'b00) || (axil_req_i.araddr > REG_CLASS_END);
        if (!rd_err) begin
            case (axil_req_i.araddr)
                REG_CTRL:    rd_data = '0;
                REG_CYCLES:  rd_data = bank_i.cycles;
                REG_RETIRED: rd_data = bank_i.retired;
                REG_RVC:     rd_data = bank_i.rvc_count;
                REG_LAST:    rd_data = {{(DATA_W - $bits(trace_record_t)){1'b0}}, bank_i.last};
                default:     rd_data = bank_i.class_count[class_off[4:2]];
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            clear_q <= 1'b0;
        end else begin
            clear_q <= wr_hs && wr_ctrl && axil_req_i.wdata[0];
            case (state_q)
                IDLE: begin
                    if (ar_hs) begin
                        state_q <= READ_RESP;
                    end else if (wr_hs) begin
                        state_q <= WRITE_RESP;
                    end
                end
                READ_RESP: if (axil_req_i.rready) state_q <= IDLE;
                WRITE_RESP: if (axil_req_i.bready) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (ar_hs) begin
            rdata_q <= rd_data;
            rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (wr_hs) begin
            bresp_q <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        axil_rsp_o.arready = state_q == IDLE;
        axil_rsp_o.awready = (state_q == IDLE) && !axil_req_i.arvalid;
        axil_rsp_o.wready  = (state_q == IDLE) && !axil_req_i.arvalid;
        axil_rsp_o.rvalid  = state_q == READ_RESP;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.bvalid  = state_q == WRITE_RESP;
        axil_rsp_o.bresp   = bresp_q;
    end

    assign clear_o = clear_q;

endmodule

//--- commit_monitor.sv
// Commit monitor top level for a small RV32IMC core.
// Classifies each retired word, keeps statistics and serves them over AXI4-Lite.
module commit_monitor import trace_pkg::*, axil_pkg::*; (
    input  logic        s_clk_i,
    input  logic        rst_n_i,
    input  logic        commit_valid_i,
    input  instr_word_u commit_instr_i,
    input  axil_req_t   axil_req_i,
    output axil_rsp_t   axil_rsp_o
);

    trace_record_t record;
    counter_bank_t bank;
    logic          clear;

    instr_classifier u_instr_classifier (
        .instr_i  (commit_instr_i),
        .record_o (record)
    );

    commit_counters u_commit_counters (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .clear_i        (clear),
        .commit_valid_i (commit_valid_i),
        .record_i       (record),
        .bank_o         (bank)
    );

    axil_regs_fsm u_axil_regs_fsm (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .bank_i     (bank),
        .clear_o    (clear)
    );

endmodule

//--- commit_monitor_checker.sv
// AXI4-Lite protocol assertions for the commit monitor slave port.
// Bound into every commit_monitor instance of the simulation.
module commit_monitor_checker import axil_pkg::*; (
    input logic      s_clk_i,
    input logic      rst_n_i,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic wr_hs;

    assign wr_hs = axil_req_i.awvalid && axil_rsp_o.awready &&
                   axil_req_i.wvalid && axil_rsp_o.wready;

    a_reset_idle: assert property (@(posedge s_clk_i)
        !rst_n_i |=> !axil_rsp_o.rvalid && !axil_rsp_o.bvalid)
        else $error("response valid high after reset");

    a_rvalid_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata))
        else $error("rvalid dropped or rdata changed before rready");

    a_bvalid_rise: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        wr_hs |=> axil_rsp_o.bvalid)
        else $error("bvalid missing one cycle after write handshake");

    a_bvalid_cause: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        $rose(axil_rsp_o.bvalid) |-> $past(wr_hs))
        else $error("bvalid rose without a write handshake");

    a_bvalid_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
        else $error("bvalid dropped before bready");

    a_arready_low: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid |-> !axil_rsp_o.arready)
        else $error("arready high while rvalid pending");

endmodule

bind commit_monitor commit_monitor_checker u_checker (
    .s_clk_i    (s_clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o)
);

//--- tb_clock_gen.sv
// Clock and reset source for the commit monitor testbench.
// 40 ns clock, reset held low for the first four rising edges.
module tb_clock_gen (
    output logic s_clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        s_clk_o = 1'b0;
        forever #20 s_clk_o = ~s_clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge s_clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- tb_commit_monitor.sv
// Testbench top for the commit monitor.
// Runs the command list from commit_tests.txt against the DUT and reports per line.
module tb_commit_monitor import trace_pkg::*, axil_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HS_LIMIT = 100;

    logic        s_clk;
    logic        rst_n;
    logic        commit_valid;
    instr_word_u commit_instr;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    logic [7:0]  cmd_q[$];
    logic [31:0] a_q[$];
    logic [31:0] b_q[$];
    logic [31:0] c_q[$];
    logic [31:0] d_q[$];

    int          seed = 12;
    int unsigned edge_count = 0;
    int          errors = 0;
    int          passed = 0;
    bit          loaded = 0;
    logic [31:0] last_word = '0;
    logic [31:0] last_cycles = '0;

    tb_clock_gen u_clock_gen (
        .s_clk_o (s_clk),
        .rst_n_o (rst_n)
    );

    commit_monitor u_dut (
        .s_clk_i        (s_clk),
        .rst_n_i        (rst_n),
        .commit_valid_i (commit_valid),
        .commit_instr_i (commit_instr),
        .axil_req_i     (axil_req),
        .axil_rsp_o     (axil_rsp)
    );

    always @(posedge s_clk) edge_count <= edge_count + 1;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen("commit_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test file commit_tests.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h %h %h", cmd, a, b, c, d);
                if (n == 5) begin
                    cmd_q.push_back(cmd);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    d_q.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic commit_word(input logic [31:0] word, input int count);
        @(posedge s_clk);
        commit_valid <= 1'b1;
        commit_instr <= word;
        repeat (count) @(posedge s_clk);
        commit_valid <= 1'b0;
        last_word = word;
    endtask

    // stall commits repeat the last committed word while rready is held back.
    task automatic axil_read(input logic [7:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp,
                             output int unsigned hs_edge);
        int n;
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(posedge s_clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        @(negedge s_clk);
        n = 0;
        while (!axil_rsp.arready && n < HS_LIMIT) begin
            @(negedge s_clk);
            n++;
        end
        if (!axil_rsp.arready) abort_run("read address handshake never completed");
        hs_edge = edge_count;
        @(posedge s_clk);
        axil_req.arvalid <= 1'b0;
        if (stall > 0) begin
            commit_valid <= 1'b1;
            commit_instr <= last_word;
            repeat (stall) @(posedge s_clk);
            commit_valid <= 1'b0;
        end
        @(negedge s_clk);
        n = 0;
        while (!axil_rsp.rvalid && n < HS_LIMIT) begin
            @(negedge s_clk);
            n++;
        end
        if (!axil_rsp.rvalid) abort_run("read data never became valid");
        repeat (delay) @(negedge s_clk);
        @(posedge s_clk);
        axil_req.rready <= 1'b1;
        @(negedge s_clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge s_clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(posedge s_clk);
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wdata   <= data;
        @(negedge s_clk);
        n = 0;
        while (!(axil_rsp.awready && axil_rsp.wready) && n < HS_LIMIT) begin
            @(negedge s_clk);
            n++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) abort_run("write handshake never completed");
        @(posedge s_clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge s_clk);
        n = 0;
        while (!axil_rsp.bvalid && n < HS_LIMIT) begin
            @(negedge s_clk);
            n++;
        end
        if (!axil_rsp.bvalid) abort_run("write response never became valid");
        @(posedge s_clk);
        axil_req.bready <= 1'b1;
        @(negedge s_clk);
        resp = axil_rsp.bresp;
        @(posedge s_clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic run_line(input int idx);
        logic [31:0] data;
        logic [31:0] data2;
        logic [1:0]  resp;
        int unsigned hs1;
        int unsigned hs2;
        bit          ok;
        ok = 1;
        case (cmd_q[idx])
            "C": commit_word(a_q[idx], int'(b_q[idx]));
            "I": repeat (a_q[idx]) @(posedge s_clk);
            "R": begin
                axil_read(a_q[idx][7:0], int'(d_q[idx]), data, resp, hs1);
                if (resp != c_q[idx][1:0]) begin
                    $display("[FAIL] %0t ns: read 0x%02h resp %0d expected %0d",
                             $time, a_q[idx][7:0], resp, c_q[idx][1:0]);
                    ok = 0;
                end
                // cycles only ever reads back lower after a clear.
                if (a_q[idx][7:0] == REG_CYCLES) begin
                    if (data >= last_cycles) begin
                        $display("[FAIL] %0t ns: cycles 0x%08h not below 0x%08h",
                                 $time, data, last_cycles);
                        ok = 0;
                    end
                    last_cycles = data;
                end else if (data != b_q[idx]) begin
                    $display("[FAIL] %0t ns: read 0x%02h got 0x%08h expected 0x%08h",
                             $time, a_q[idx][7:0], data, b_q[idx]);
                    ok = 0;
                end
            end
            "W": begin
                axil_write(a_q[idx][7:0], b_q[idx], resp);
                if (resp != c_q[idx][1:0]) begin
                    $display("[FAIL] %0t ns: write 0x%02h resp %0d expected %0d",
                             $time, a_q[idx][7:0], resp, c_q[idx][1:0]);
                    ok = 0;
                end
            end
            "Q": begin
                axil_read(REG_CYCLES, 0, data, resp, hs1);
                repeat (a_q[idx]) @(posedge s_clk);
                axil_read(REG_CYCLES, 0, data2, resp, hs2);
                if (data2 - data != hs2 - hs1) begin
                    $display("[FAIL] %0t ns: cycles moved %0d over %0d edges",
                             $time, data2 - data, hs2 - hs1);
                    ok = 0;
                end
                last_cycles = data2;
            end
            default: begin
                $display("unknown command in test line %0d", idx);
                ok = 0;
            end
        endcase
        if (ok) begin
            passed++;
        end else begin
            errors++;
        end
        $display("test %0d %c: %s", idx, cmd_q[idx], ok ? "ok" : "mismatch");
    endtask

    initial begin
        commit_valid = 1'b0;
        commit_instr = '0;
        axil_req     = '0;
        load_tests();
        loaded = 1;
        wait (rst_n === 1'b1);
        foreach (cmd_q[i]) begin
            run_line(i);
        end
        $display("tests %0d, passed %0d, failed %0d", cmd_q.size(), passed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(cmd_q.size()) * 200 * 40 + 400;
        #(limit_ns);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- commit_tests.txt
# columns: cmd a b c d, all hex. C word count | I cycles | Q idle_cycles
# R addr expected resp stall_commits | W addr data resp unused. R of 04 expects a drop.
C 00500093 1 0 0
C 0000A203 1 0 0
C 0020A023 1 0 0
C 00208063 1 0 0
C 000000EF 1 0 0
C 00008067 1 0 0
C 30031273 1 0 0
C 022081B3 1 0 0
R 08 00000008 0 0
R 14 00000001 0 0
R 18 00000001 0 0
R 1C 00000001 0 0
R 20 00000001 0 0
R 24 00000001 0 0
R 28 00000001 0 0
R 2C 00000001 0 0
R 30 00000001 0 0
R 0C 00000000 0 0
R 10 000458E1 0 0
C 0000C026 1 0 0
C 00000405 1 0 0
C 0000A001 1 0 0
C 0000C001 1 0 0
C 0000852E 1 0 0
C 00004104 1 0 0
R 0C 00000006 0 0
R 08 0000000E 0 0
R 14 00000003 0 0
R 1C 00000002 0 0
R 10 00281272 0 0
R 00 00000000 0 0
R 34 00000000 2 0
R 06 00000000 2 0
W 08 00000005 2 0
R 08 0000000E 0 0
Q 0A 0 0 0
I 3 0 0 0
R 08 0000000E 0 5
R 08 00000013 0 0
R 0C 0000000B 0 0
R 1C 00000007 0 3
R 1C 0000000A 0 0
R 08 00000016 0 0
W 00 00000001 0 0
I 2 0 0 0
R 08 00000000 0 0
R 0C 00000000 0 0
R 10 00000000 0 0
R 14 00000000 0 0
R 1C 00000000 0 0
R 04 00000000 0 0

//--- sim.f
trace_pkg.sv
axil_pkg.sv
rvc_classifier.sv
instr_classifier.sv
commit_counters.sv
axil_regs_fsm.sv
commit_monitor.sv
commit_monitor_checker.sv
tb_clock_gen.sv
tb_commit_monitor.sv

//--- Bender.yml
package:
  name: commit_monitor

sources:
  - trace_pkg.sv
  - axil_pkg.sv
  - rvc_classifier.sv
  - instr_classifier.sv
  - commit_counters.sv
  - axil_regs_fsm.sv
  - commit_monitor.sv
  - target: test
    files:
      - commit_monitor_checker.sv
      - tb_clock_gen.sv
      - tb_commit_monitor.sv
